// File: cacheLite.f
source/cachePkg.sv
source/ram2p1r1wbe.sv
source/cacheTagStore.sv
source/cacheDataStore.sv
source/cacheController.sv
source/cacheTop.sv
sim/cacheTop_sva.sv
sim/cacheTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the cacheLite testbench with Verilator
# Exit status is non-zero when the run reports failure

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --top-module cacheTb \
    -f cacheLite.f -o VcacheTb; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/VcacheTb > "$LOG" 2>&1
runStatus=$?
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
  exit 1
fi

if [ "$runStatus" -ne 0 ]; then
  echo "Simulation exited with status $runStatus"
  exit 1
fi

exit 0

// File: sim/cacheTb.sv
`timescale 1ns/1ps
// Testbench for the cacheLite direct-mapped write-through cache
// Directed tests against a stalling memory responder and a per-set reference model

module cacheTb;

  localparam int MemWords = 1 << (cachePkg::AddrWidth - cachePkg::OffsetWidth);
  // Each directed or random operation fits in about 16 cycles
  localparam int NumOps        = 250;
  localparam int CyclesPerOp   = 16;
  localparam int TimeoutCycles = NumOps * CyclesPerOp;

  logic                           clk         = 1'b0;
  logic                           rstN        = 1'b0;
  logic                           cpuReqValid = 1'b0;
  cachePkg::cpuReqT               cpuReq      = '0;
  logic                           cpuReqReady;
  logic                           cpuRspValid;
  cachePkg::cpuRspT               cpuRsp;
  logic                           cpuRspReady = 1'b0;
  logic                           memReqValid;
  cachePkg::memReqT               memReq;
  logic                           memReqReady = 1'b0;
  logic                           memRspValid = 1'b0;
  logic [cachePkg::WordWidth-1:0] memRspData  = '0;
  logic                           flush       = 1'b0;

  // Memory responder
  logic [cachePkg::WordWidth-1:0] memArray [MemWords];
  logic [cachePkg::WordWidth-1:0] rspWord   = '0;
  int                             rspLeft   = 0;
  int                             stallLeft = 0;

  // Reference model of memory plus per-set tag and valid
  logic [cachePkg::WordWidth-1:0] refMem [MemWords];
  logic [cachePkg::TagWidth-1:0]  refTag [cachePkg::NumSets];
  logic [cachePkg::NumSets-1:0]   refValid = '0;

  int cycleCount     = 0;
  bit randomRspReady = 1'b0;

  cacheTop u_cacheTop (
    .clk         (clk),
    .rstN        (rstN),
    .cpuReqValid (cpuReqValid),
    .cpuReq      (cpuReq),
    .cpuReqReady (cpuReqReady),
    .cpuRspValid (cpuRspValid),
    .cpuRsp      (cpuRsp),
    .cpuRspReady (cpuRspReady),
    .memReqValid (memReqValid),
    .memReq      (memReq),
    .memReqReady (memReqReady),
    .memRspValid (memRspValid),
    .memRspData  (memRspData),
    .flush       (flush)
  );

  always #2 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TimeoutCycles) begin
      $display("Timeout: no finish within %0d cycles", TimeoutCycles);
      $display("Result: FAILED");
      $fatal(1);
    end
  end

  // CPU response back-pressure is random only in the random test
  always @(posedge clk) begin
    if (!rstN) begin
      cpuRspReady <= 1'b0;
    end else if (randomRspReady) begin
      cpuRspReady <= 1'($urandom_range(0, 1));
    end else begin
      cpuRspReady <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Memory responder
  ////////////////////////////////////////////////////////////////////////////

  // Accept after 0 to 3 stall cycles and answer reads 1 to 4 cycles later
  always @(posedge clk) begin
    if (!rstN) begin
      memReqReady <= 1'b0;
      memRspValid <= 1'b0;
      rspLeft     <= 0;
      stallLeft   <= $urandom_range(0, 3);
    end else begin
      memRspValid <= 1'b0;
      if (rspLeft != 0) begin
        if (rspLeft == 1) begin
          memRspValid <= 1'b1;
          memRspData  <= rspWord;
        end
        rspLeft <= rspLeft - 1;
      end
      if (memReqValid && memReqReady) begin
        memReqReady <= 1'b0;
        stallLeft   <= $urandom_range(0, 3);
        if (memReq.write) begin
          for (int l = 0; l < cachePkg::ByteLanes; l++) begin
            if (memReq.byteEn[l]) begin
              memArray[memReq.addr][8*l +: 8] = memReq.wdata[8*l +: 8];
            end
          end
        end else begin
          rspWord <= memArray[memReq.addr];
          rspLeft <= $urandom_range(1, 4);
        end
      end else if (memReqValid) begin
        if (stallLeft == 0) begin
          memReqReady <= 1'b1;
        end else begin
          stallLeft <= stallLeft - 1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s, got %h expected %h", $time, what, got, exp);
      $display("Result: FAILED");
      $fatal(1);
    end
  endtask

  function automatic cachePkg::cacheAddrT makeAddr(input logic [cachePkg::TagWidth-1:0] tag,
                                                   input logic [cachePkg::IndexWidth-1:0] index,
                                                   input logic [1:0] offset);
    cachePkg::cacheAddrT a;
    a.tag        = tag;
    a.index      = index;
    a.byteOffset = offset;
    return a;
  endfunction

  // Runs one CPU access and checks it against the model before updating it
  task automatic runOp(input cachePkg::cacheAddrT addr, input logic write,
                       input logic [31:0] wdata, input logic [3:0] byteEn,
                       output logic gotHit);
    cachePkg::cpuReqT req;
    logic [15:0]      wordAddr;
    logic             expHit;
    logic [31:0]      expData;
    int               acceptCycle;
    int               firstValid;
    bit               seenValid;
    wordAddr    = {addr.tag, addr.index};
    expHit      = refValid[addr.index] && (refTag[addr.index] == addr.tag);
    req.addr    = addr;
    req.write   = write;
    req.wdata   = wdata;
    req.byteEn  = byteEn;
    cpuReqValid <= 1'b1;
    cpuReq      <= req;
    @(posedge clk);
    while (!(cpuReqValid && cpuReqReady)) begin
      @(posedge clk);
    end
    acceptCycle = cycleCount;
    cpuReqValid <= 1'b0;
    seenValid   = 1'b0;
    firstValid  = 0;
    do begin
      @(posedge clk);
      if (cpuRspValid && !seenValid) begin
        seenValid  = 1'b1;
        firstValid = cycleCount;
      end
    end while (!(cpuRspValid && cpuRspReady));
    // Writes merge into memory and read misses allocate but write misses do not
    if (write) begin
      expData = '0;
      for (int l = 0; l < 4; l++) begin
        if (byteEn[l]) begin
          refMem[wordAddr][8*l +: 8] = wdata[8*l +: 8];
        end
      end
    end else begin
      expData               = refMem[wordAddr];
      refValid[addr.index]  = 1'b1;
      refTag[addr.index]    = addr.tag;
    end
    checkEq("response hit flag", 32'(cpuRsp.hit), 32'(expHit));
    checkEq("response data", cpuRsp.rdata, expData);
    if (write) begin
      checkEq("memory word after write-through", memArray[wordAddr], refMem[wordAddr]);
    end else if (expHit) begin
      checkEq("read hit latency in cycles", firstValid - acceptCycle, 2);
    end
    gotHit = cpuRsp.hit;
  endtask

  // Single-cycle flush while the cache is idle
  task automatic doFlush();
    flush <= 1'b1;
    @(posedge clk);
    checkEq("request ready during flush", 32'(cpuReqReady), 0);
    flush    <= 1'b0;
    refValid = '0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic testMissThenHit();
    logic h;
    runOp(makeAddr(10'h155, 6'd5, 2'd0), 1'b0, '0, '0, h);
    checkEq("fresh read hit flag", 32'(h), 0);
    runOp(makeAddr(10'h155, 6'd5, 2'd0), 1'b0, '0, '0, h);
    checkEq("re-read hit flag", 32'(h), 1);
  endtask

  task automatic testWriteHitMerge();
    logic h;
    runOp(makeAddr(10'h155, 6'd5, 2'd0), 1'b1, 32'hA5A5_5A5A, 4'b0101, h);
    checkEq("partial write hit flag", 32'(h), 1);
    runOp(makeAddr(10'h155, 6'd5, 2'd3), 1'b0, '0, '0, h);
    checkEq("read after merge hit flag", 32'(h), 1);
  endtask

  task automatic testWriteMissNoAllocate();
    logic h;
    runOp(makeAddr(10'h2AA, 6'd9, 2'd0), 1'b1, 32'h1234_5678, 4'b1111, h);
    checkEq("write miss hit flag", 32'(h), 0);
    runOp(makeAddr(10'h2AA, 6'd9, 2'd0), 1'b0, '0, '0, h);
    checkEq("read after write miss hit flag", 32'(h), 0);
  endtask

  // Two tags in the same set
  task automatic testConflictEviction();
    logic h;
    runOp(makeAddr(10'h011, 6'd20, 2'd0), 1'b0, '0, '0, h);
    runOp(makeAddr(10'h3F0, 6'd20, 2'd0), 1'b0, '0, '0, h);
    runOp(makeAddr(10'h011, 6'd20, 2'd1), 1'b0, '0, '0, h);
    checkEq("evicted address hit flag", 32'(h), 0);
    runOp(makeAddr(10'h011, 6'd20, 2'd2), 1'b0, '0, '0, h);
    checkEq("refilled address hit flag", 32'(h), 1);
    runOp(makeAddr(10'h3F0, 6'd20, 2'd0), 1'b0, '0, '0, h);
    checkEq("other tag after eviction hit flag", 32'(h), 0);
  endtask

  task automatic testFlush();
    logic h;
    runOp(makeAddr(10'h155, 6'd5, 2'd0), 1'b0, '0, '0, h);
    checkEq("cached before flush hit flag", 32'(h), 1);
    doFlush();
    runOp(makeAddr(10'h155, 6'd5, 2'd0), 1'b0, '0, '0, h);
    checkEq("after flush hit flag", 32'(h), 0);
    runOp(makeAddr(10'h2AA, 6'd9, 2'd0), 1'b0, '0, '0, h);
    checkEq("second set after flush hit flag", 32'(h), 0);
  endtask

  // Small tag and index pool so hits, misses and evictions all occur
  task automatic testRandomTraffic();
    logic                h;
    cachePkg::cacheAddrT a;
    logic                wr;
    randomRspReady = 1'b1;
    for (int i = 0; i < 200; i++) begin
      if ($urandom_range(0, 19) == 0) begin
        doFlush();
      end
      a  = makeAddr({2'($urandom_range(0, 3)), 8'h5A}, 6'($urandom_range(0, 7)),
                    2'($urandom_range(0, 3)));
      wr = ($urandom_range(0, 2) == 0);
      runOp(a, wr, $urandom, 4'($urandom_range(0, 15)), h);
    end
    randomRspReady = 1'b0;
  endtask

  initial begin
    void'($urandom(85521));
    for (int i = 0; i < MemWords; i++) begin
      memArray[i] = $urandom;
      refMem[i]   = memArray[i];
    end
    for (int s = 0; s < cachePkg::NumSets; s++) begin
      refTag[s] = '0;
    end
    repeat (3) @(posedge clk);
    rstN <= 1'b1;
    @(posedge clk);
    checkEq("request ready after reset", 32'(cpuReqReady), 1);
    checkEq("response valid after reset", 32'(cpuRspValid), 0);
    checkEq("memory request valid after reset", 32'(memReqValid), 0);
    testMissThenHit();
    testWriteHitMerge();
    testWriteMissNoAllocate();
    testConflictEviction();
    testFlush();
    testRandomTraffic();
    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: sim/cacheTop_sva.sv
`timescale 1ns/1ps
// Handshake assertions for the cacheLite top level
// Bound into cacheTop, checks valid/ready rules on CPU and memory ports

module cacheTopSva (
  input logic             clk,
  input logic             rstN,
  input logic             cpuReqValid,
  input logic             cpuReqReady,
  input logic             cpuRspValid,
  input cachePkg::cpuRspT cpuRsp,
  input logic             cpuRspReady,
  input logic             memReqValid,
  input cachePkg::memReqT memReq,
  input logic             memReqReady
);

  // Set on an accepted request, cleared when its response is taken
  logic reqPending;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      reqPending <= 1'b0;
    end else if (cpuRspValid && cpuRspReady) begin
      reqPending <= 1'b0;
    end else if (cpuReqValid && cpuReqReady) begin
      reqPending <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stability under back-pressure
  ////////////////////////////////////////////////////////////////////////////

  rspHold: assert property (@(posedge clk) disable iff (!rstN)
    cpuRspValid && !cpuRspReady |=> cpuRspValid && $stable(cpuRsp))
    else $error("CPU response dropped or changed while stalled");

  memReqHold: assert property (@(posedge clk) disable iff (!rstN)
    memReqValid && !memReqReady |=> memReqValid && $stable(memReq))
    else $error("memory request dropped or changed while stalled");

  ////////////////////////////////////////////////////////////////////////////
  // Ordering
  ////////////////////////////////////////////////////////////////////////////

  rspNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
    cpuRspValid |-> reqPending)
    else $error("CPU response without an accepted request");

  // One request in flight at a time
  noReqWhilePending: assert property (@(posedge clk) disable iff (!rstN)
    reqPending |-> !cpuReqReady)
    else $error("request ready while a response is pending");

endmodule

bind cacheTop cacheTopSva u_cacheTopSva (
  .clk         (clk),
  .rstN        (rstN),
  .cpuReqValid (cpuReqValid),
  .cpuReqReady (cpuReqReady),
  .cpuRspValid (cpuRspValid),
  .cpuRsp      (cpuRsp),
  .cpuRspReady (cpuRspReady),
  .memReqValid (memReqValid),
  .memReq      (memReq),
  .memReqReady (memReqReady)
);

// File: source/cacheTop.sv
`timescale 1ns/1ps
// cacheLite top level
// Direct-mapped write-through data cache between a CPU and memory

module cacheTop (
  input  logic                           clk,
  input  logic                           rstN,
  // CPU side
  input  logic                           cpuReqValid,
  input  cachePkg::cpuReqT               cpuReq,
  output logic                           cpuReqReady,
  output logic                           cpuRspValid,
  output cachePkg::cpuRspT               cpuRsp,
  input  logic                           cpuRspReady,
  // Memory side
  output logic                           memReqValid,
  output cachePkg::memReqT               memReq,
  input  logic                           memReqReady,
  input  logic                           memRspValid,
  input  logic [cachePkg::WordWidth-1:0] memRspData,
  // Single-cycle invalidate
  input  logic                           flush
);

  // Lookup
  logic                            lookupEn;
  logic [cachePkg::IndexWidth-1:0] lookupIndex;
  logic [cachePkg::TagWidth-1:0]   lookupTag;
  logic                            hit;
  logic [cachePkg::WordWidth-1:0]  readData;
  // Writes into the stores
  logic                            tagWriteEn;
  logic                            dataWriteEn;
  logic [cachePkg::IndexWidth-1:0] fillIndex;
  logic [cachePkg::TagWidth-1:0]   fillTag;
  logic                            fillSel;
  logic [cachePkg::WordWidth-1:0]  storeData;
  logic [cachePkg::ByteLanes-1:0]  storeByteEn;
  logic [cachePkg::WordWidth-1:0]  fillData;
  logic                            flushSets;

  cacheController u_cacheController (.*);

  cacheTagStore u_cacheTagStore (
    .clk         (clk),
    .rstN        (rstN),
    .lookupEn    (lookupEn),
    .lookupIndex (lookupIndex),
    .lookupTag   (lookupTag),
    .hit         (hit),
    .tagWriteEn  (tagWriteEn),
    .fillIndex   (fillIndex),
    .fillTag     (fillTag),
    .flush       (flushSets)
  );

  cacheDataStore u_cacheDataStore (
    .clk         (clk),
    .lookupEn    (lookupEn),
    .lookupIndex (lookupIndex),
    .readData    (readData),
    .dataWriteEn (dataWriteEn),
    .writeIndex  (fillIndex),
    .fillSel     (fillSel),
    .storeData   (storeData),
    .storeByteEn (storeByteEn),
    .fillData    (fillData)
  );

endmodule

// File: source/cacheController.sv
`timescale 1ns/1ps
// Cache controller FSM
// Accepts CPU requests, runs lookup, miss fill, write-through and response

module cacheController (
  input  logic                            clk,
  input  logic                            rstN,
  // CPU request
  input  logic                            cpuReqValid,
  input  cachePkg::cpuReqT                cpuReq,
  output logic                            cpuReqReady,
  // CPU response
  output logic                            cpuRspValid,
  output cachePkg::cpuRspT                cpuRsp,
  input  logic                            cpuRspReady,
  // Memory request
  output logic                            memReqValid,
  output cachePkg::memReqT                memReq,
  input  logic                            memReqReady,
  // Memory response, no ready
  input  logic                            memRspValid,
  input  logic [cachePkg::WordWidth-1:0]  memRspData,
  // Invalidate request from outside
  input  logic                            flush,
  // Store read ports
  output logic                            lookupEn,
  output logic [cachePkg::IndexWidth-1:0] lookupIndex,
  output logic [cachePkg::TagWidth-1:0]   lookupTag,
  input  logic                            hit,
  input  logic [cachePkg::WordWidth-1:0]  readData,
  // Store write ports
  output logic                            tagWriteEn,
  output logic                            dataWriteEn,
  output logic [cachePkg::IndexWidth-1:0] fillIndex,
  output logic [cachePkg::TagWidth-1:0]   fillTag,
  output logic                            fillSel,
  output logic [cachePkg::WordWidth-1:0]  storeData,
  output logic [cachePkg::ByteLanes-1:0]  storeByteEn,
  output logic [cachePkg::WordWidth-1:0]  fillData,
  // Flush qualified by Idle
  output logic                            flushSets
);

  typedef enum logic [2:0] {
    Idle,
    Lookup,
    MemReq,
    MemWait,
    Respond
  } stateT;

  stateT            state;
  stateT            stateNext;
  cachePkg::cpuReqT reqQ;
  cachePkg::cpuRspT rspQ;
  logic             reqAccept;
  logic             fillNow;

  ////////////////////////////////////////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////////////////////////////////////////

  // Flush takes the Idle cycle, no request that cycle
  assign flushSets   = (state == Idle) && flush;
  assign cpuReqReady = (state == Idle) && !flush;
  assign reqAccept   = cpuReqValid && cpuReqReady;

  assign memReqValid = (state == MemReq);
  assign cpuRspValid = (state == Respond);
  assign cpuRsp      = rspQ;

  // Word address is tag and index, offset dropped
  assign memReq.addr   = {reqQ.addr.tag, reqQ.addr.index};
  assign memReq.write  = reqQ.write;
  assign memReq.wdata  = reqQ.wdata;
  // Reads fetch the full word
  assign memReq.byteEn = reqQ.write ? reqQ.byteEn : '1;

  ////////////////////////////////////////////////////////////////////////////
  // Store control
  ////////////////////////////////////////////////////////////////////////////

  // Lookup straight from the incoming request
  assign lookupEn    = reqAccept;
  assign lookupIndex = cpuReq.addr.index;
  assign lookupTag   = cpuReq.addr.tag;

  // Read miss fill on the memory response edge
  assign fillNow     = (state == MemWait) && memRspValid;
  assign tagWriteEn  = fillNow;
  // Write hit merges its bytes during Lookup
  assign dataWriteEn = fillNow || ((state == Lookup) && reqQ.write && hit);
  assign fillSel     = (state == MemWait);

  // Write index and tag from the captured request
  assign fillIndex   = reqQ.addr.index;
  assign fillTag     = reqQ.addr.tag;
  assign storeData   = reqQ.wdata;
  assign storeByteEn = reqQ.byteEn;
  assign fillData    = memRspData;

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    stateNext = state;
    case (state)
      Idle:    if (reqAccept) stateNext = Lookup;
      // Read hit answers at once, everything else goes to memory
      Lookup:  stateNext = (!reqQ.write && hit) ? Respond : MemReq;
      MemReq:  if (memReqReady) stateNext = reqQ.write ? Respond : MemWait;
      MemWait: if (memRspValid) stateNext = Respond;
      Respond: if (cpuRspReady) stateNext = Idle;
      default: stateNext = Idle;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= Idle;
    end else begin
      state <= stateNext;
    end
  end

  // Request and response payloads
  always_ff @(posedge clk) begin
    if (reqAccept) begin
      reqQ <= cpuReq;
    end
    // Writes carry hit with zero data, a read miss is overwritten below
    if (state == Lookup) begin
      rspQ.rdata <= reqQ.write ? '0 : readData;
      rspQ.hit   <= hit;
    end
    if (fillNow) begin
      rspQ.rdata <= memRspData;
      rspQ.hit   <= 1'b0;
    end
  end

endmodule

// File: source/cacheDataStore.sv
`timescale 1ns/1ps
// Data store for the direct-mapped cache
// One word per set, written by a memory fill or a CPU store merge

module cacheDataStore (
  input  logic                             clk,
  // Lookup, readData is valid the cycle after lookupEn
  input  logic                             lookupEn,
  input  logic [cachePkg::IndexWidth-1:0]  lookupIndex,
  output logic [cachePkg::WordWidth-1:0]   readData,
  // Single write port
  input  logic                             dataWriteEn,
  input  logic [cachePkg::IndexWidth-1:0]  writeIndex,
  // High selects the fill word, low the CPU store
  input  logic                             fillSel,
  input  logic [cachePkg::WordWidth-1:0]   storeData,
  input  logic [cachePkg::ByteLanes-1:0]   storeByteEn,
  input  logic [cachePkg::WordWidth-1:0]   fillData
);

  logic [cachePkg::WordWidth-1:0] writeData;
  logic [cachePkg::ByteLanes-1:0] writeByteEn;

  // Fill replaces the whole word, store touches only its lanes
  assign writeData   = fillSel ? fillData : storeData;
  assign writeByteEn = fillSel ? '1 : storeByteEn;

  ram2p1r1wbe #(
    .DEPTH (cachePkg::NumSets),
    .WIDTH (cachePkg::WordWidth)
  ) u_dataRam (
    .clk  (clk),
    .ce1  (lookupEn),
    .ra1  (lookupIndex),
    .rd1  (readData),
    .ce2  (dataWriteEn),
    .we2  (dataWriteEn),
    .wa2  (writeIndex),
    .wd2  (writeData),
    .bwe2 (writeByteEn)
  );

endmodule

// File: source/cacheTagStore.sv
`timescale 1ns/1ps
// Tag store for the direct-mapped cache
// Tag SRAM plus resettable valid flags, yields hit for the looked-up set

module cacheTagStore (
  input  logic                            clk,
  input  logic                            rstN,
  // Lookup, hit is valid the cycle after lookupEn
  input  logic                            lookupEn,
  input  logic [cachePkg::IndexWidth-1:0] lookupIndex,
  input  logic [cachePkg::TagWidth-1:0]   lookupTag,
  output logic                            hit,
  // Fill on a read miss
  input  logic                            tagWriteEn,
  input  logic [cachePkg::IndexWidth-1:0] fillIndex,
  input  logic [cachePkg::TagWidth-1:0]   fillTag,
  // Invalidate every set
  input  logic                            flush
);

  logic [cachePkg::NumSets-1:0]  validQ;
  logic                          validRdQ;
  logic [cachePkg::TagWidth-1:0] lookupTagQ;
  logic [cachePkg::TagWidth-1:0] storedTag;

  // Tag array, all lanes written on a fill
  ram2p1r1wbe #(
    .DEPTH (cachePkg::NumSets),
    .WIDTH (cachePkg::TagWidth)
  ) u_tagRam (
    .clk  (clk),
    .ce1  (lookupEn),
    .ra1  (lookupIndex),
    .rd1  (storedTag),
    .ce2  (tagWriteEn),
    .we2  (tagWriteEn),
    .wa2  (fillIndex),
    .wd2  (fillTag),
    .bwe2 ('1)
  );

  // Valid flags live in flops so reset and flush can clear them
  // Flush wins, it is only raised while no fill is in flight
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validQ   <= '0;
      validRdQ <= 1'b0;
    end else begin
      if (flush) begin
        validQ <= '0;
      end else if (tagWriteEn) begin
        validQ[fillIndex] <= 1'b1;
      end
      // Valid read lines up with the SRAM read
      if (lookupEn) begin
        validRdQ <= validQ[lookupIndex];
      end
    end
  end

  // Compare tag travels with the read
  always_ff @(posedge clk) begin
    if (lookupEn) begin
      lookupTagQ <= lookupTag;
    end
  end

  assign hit = validRdQ && (storedTag == lookupTagQ);

endmodule

// File: source/ram2p1r1wbe.sv
`timescale 1ns/1ps
// Two-port SRAM, one read port and one write port
// Behavioral read-first model with byte write enables

module ram2p1r1wbe #(
  parameter int DEPTH = 64,
  parameter int WIDTH = 32
) (
  input  logic                     clk,
  // Read port
  input  logic                     ce1,
  input  logic [$clog2(DEPTH)-1:0] ra1,
  output logic [WIDTH-1:0]         rd1,
  // Write port
  input  logic                     ce2,
  input  logic                     we2,
  input  logic [$clog2(DEPTH)-1:0] wa2,
  input  logic [WIDTH-1:0]         wd2,
  // One enable per byte, top bit also covers leftover MSBs
  input  logic [(WIDTH-1)/8:0]     bwe2
);

  // Storage, no reset on SRAM contents
  logic [WIDTH-1:0] mem [DEPTH];

  // Per-bit write mask expanded from the lane enables
  logic [WIDTH-1:0] bitMask;

  ////////////////////////////////////////////////////////////////////////////
  // Write
  ////////////////////////////////////////////////////////////////////////////

  // Bit b belongs to lane b/8
  // For a width like 10 the last lane holds only 2 bits
  always_comb begin
    for (int b = 0; b < WIDTH; b++) begin
      bitMask[b] = bwe2[b/8];
    end
  end

  // Merge enabled lanes, keep the rest of the word
  always_ff @(posedge clk) begin
    if (ce2 && we2) begin
      mem[wa2] <= (mem[wa2] & ~bitMask) | (wd2 & bitMask);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read
  ////////////////////////////////////////////////////////////////////////////

  // Address sampled on an enabled edge, word valid just after it
  // Same-edge write to the same word returns the old contents
  // Output holds until the next enabled read
  always_ff @(posedge clk) begin
    if (ce1) begin
      rd1 <= mem[ra1];
    end
  end

endmodule

// File: source/cachePkg.sv
// cacheLite shared definitions
// Cache geometry plus the CPU, response and memory request payloads

package cachePkg;

  ////////////////////////////////////////////////////////////////////////////
  // Geometry
  ////////////////////////////////////////////////////////////////////////////

  // CPU byte address
  localparam int AddrWidth   = 18;
  localparam int WordWidth   = 32;
  // One word per set, direct mapped
  localparam int NumSets     = 64;
  localparam int OffsetWidth = 2;
  localparam int IndexWidth  = 6;
  // Whatever is left above index and offset
  localparam int TagWidth    = AddrWidth - IndexWidth - OffsetWidth;
  localparam int ByteLanes   = WordWidth / 8;

  ////////////////////////////////////////////////////////////////////////////
  // Payloads
  ////////////////////////////////////////////////////////////////////////////

  // Byte address split, MSB first
  typedef struct packed {
    logic [TagWidth-1:0]    tag;
    logic [IndexWidth-1:0]  index;
    logic [OffsetWidth-1:0] byteOffset;
  } cacheAddrT;

  // CPU load or store
  typedef struct packed {
    cacheAddrT              addr;
    logic                   write;
    logic [WordWidth-1:0]   wdata;
    logic [ByteLanes-1:0]   byteEn;
  } cpuReqT;

  // Load data and hit flag back to the CPU
  typedef struct packed {
    logic [WordWidth-1:0]   rdata;
    logic                   hit;
  } cpuRspT;

  // Word addressed memory request
  typedef struct packed {
    logic [AddrWidth-OffsetWidth-1:0] addr;
    logic                             write;
    logic [WordWidth-1:0]             wdata;
    logic [ByteLanes-1:0]             byteEn;
  } memReqT;

endpackage
